/* hw/llc_pkg.sv */
// field widths and types shared by the LLC local memory
// state code zero is taken as invalid, so a flush writes zeros
`default_nettype none

package llc_pkg;

    localparam int LLC_TAG_BITS     = 16;
    localparam int LLC_LINE_BITS    = 128;
    localparam int LLC_OWNER_BITS   = 4;
    localparam int LLC_SHARERS_BITS = 16;
    localparam int LLC_STATE_BITS   = 3;

    typedef logic [LLC_TAG_BITS-1:0]     llc_tag_t;
    typedef logic [LLC_LINE_BITS-1:0]    line_t;
    typedef logic [LLC_OWNER_BITS-1:0]   owner_t;
    // one presence bit per sharing cache
    typedef logic [LLC_SHARERS_BITS-1:0] sharers_t;
    typedef logic                        hprot_t;
    typedef logic [LLC_STATE_BITS-1:0]   llc_state_t;

    localparam llc_state_t LLC_STATE_INVALID = '0;

endpackage

`default_nettype wire

/* hw/llc_mem_if.sv */
// command bus from the flush controller to the storage arrays
// LLC_WAYS must be at least 2 and LLC_SETS a power of two
`timescale 1ns/1ps
`default_nettype none

interface llc_mem_if #(
    parameter int LLC_WAYS = 4,
    parameter int LLC_SETS = 16
) ();

    logic [$clog2(LLC_SETS)-1:0] set;
    logic                        rd_en;
    // one-hot full write, all-ones clear during a flush
    logic [LLC_WAYS-1:0]         wr_ways;
    logic [LLC_WAYS-1:0]         clr_ways;
    logic                        wr_evict;

    llc_pkg::llc_tag_t           tag;
    llc_pkg::llc_state_t         state;
    llc_pkg::sharers_t           sharers;
    llc_pkg::owner_t             owner;
    llc_pkg::hprot_t             hprot;
    logic                        dirty;
    llc_pkg::line_t              line;
    logic [$clog2(LLC_WAYS)-1:0] evict_way;

    modport ctrl (
        output set, rd_en, wr_ways, clr_ways, wr_evict,
        output tag, state, sharers, owner, hprot, dirty, line, evict_way
    );

    modport mem (
        input set, rd_en, wr_ways, clr_ways, wr_evict,
        input tag, state, sharers, owner, hprot, dirty, line, evict_way
    );

endinterface

`default_nettype wire

/* hw/llc_flush_ctrl.sv */
// flush sequencer, user commands are dropped while busy is high
// a flush_req that arrives during a flush is ignored
`timescale 1ns/1ps
`default_nettype none

module llc_flush_ctrl #(
    parameter int LLC_WAYS = 4,
    parameter int LLC_SETS = 16,
    localparam int WAY_BITS = $clog2(LLC_WAYS),
    localparam int SET_BITS = $clog2(LLC_SETS)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_req,
    input  logic                rd_en,
    input  logic                wr_en,
    input  logic                wr_en_evict_way,
    input  logic [SET_BITS-1:0] set_in,
    input  logic [WAY_BITS-1:0] way,
    input  llc_pkg::llc_tag_t   wr_data_tag,
    input  llc_pkg::llc_state_t wr_data_state,
    input  llc_pkg::sharers_t   wr_data_sharers,
    input  llc_pkg::owner_t     wr_data_owner,
    input  llc_pkg::hprot_t     wr_data_hprot,
    input  logic                wr_data_dirty_bit,
    input  llc_pkg::line_t      wr_data_line,
    input  logic [WAY_BITS-1:0] wr_data_evict_way,
    output logic                cnt_en,
    input  logic [SET_BITS-1:0] cnt_set,
    input  logic                cnt_last,
    output logic                busy,
    llc_mem_if.ctrl             mem_if
);

    localparam logic FLUSH = 1'b0;
    localparam logic IDLE  = 1'b1;

    logic state;
    logic state_next;

    // reset lands in FLUSH so the arrays are cleared on the way out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FLUSH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FLUSH:   if (cnt_last) state_next = IDLE;
            default: if (flush_req) state_next = FLUSH;
        endcase
    end

    assign busy   = (state == FLUSH);
    assign cnt_en = (state == FLUSH);

    always_comb begin
        mem_if.set      = set_in;
        mem_if.rd_en    = 1'b0;
        mem_if.wr_ways  = '0;
        mem_if.clr_ways = '0;
        mem_if.wr_evict = 1'b0;
        if (state == FLUSH) begin
            mem_if.set      = cnt_set;
            mem_if.clr_ways = '1;
        end else begin
            mem_if.rd_en    = rd_en;
            mem_if.wr_evict = wr_en_evict_way;
            // way decoded to a one-hot write mask
            mem_if.wr_ways  = LLC_WAYS'(wr_en) << way;
        end
    end

    assign mem_if.tag       = wr_data_tag;
    assign mem_if.state     = wr_data_state;
    assign mem_if.sharers   = wr_data_sharers;
    assign mem_if.owner     = wr_data_owner;
    assign mem_if.hprot     = wr_data_hprot;
    assign mem_if.dirty     = wr_data_dirty_bit;
    assign mem_if.line      = wr_data_line;
    assign mem_if.evict_way = wr_data_evict_way;

    // user writes never reach the arrays while the flush owns the set index
    a_no_wr_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
        (state == FLUSH) |-> (mem_if.wr_ways == '0));

endmodule

`default_nettype wire

/* hw/llc_set_counter.sv */
// set index walker for the flush, wraps so each flush starts at set 0
`timescale 1ns/1ps
`default_nettype none

module llc_set_counter #(
    parameter int LLC_SETS = 16,
    localparam int SET_BITS = $clog2(LLC_SETS)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    output logic [SET_BITS-1:0] set,
    output logic                last
);

    assign last = (set == SET_BITS'(LLC_SETS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            set <= '0;
        end else if (en) begin
            set <= last ? '0 : set + 1'b1;
        end
    end

    a_set_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(set) <= LLC_SETS - 1);

endmodule

`default_nettype wire

/* hw/llc_meta_mem.sv */
// directory metadata per way, read port registered on rd_en
// a full write takes priority over a flush clear of the same way
`timescale 1ns/1ps
`default_nettype none

module llc_meta_mem #(
    parameter int LLC_WAYS = 4,
    parameter int LLC_SETS = 16
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    llc_mem_if.mem                               mem_if,
    output llc_pkg::llc_tag_t   [LLC_WAYS-1:0]   rd_tag,
    output llc_pkg::llc_state_t [LLC_WAYS-1:0]   rd_state,
    output llc_pkg::sharers_t   [LLC_WAYS-1:0]   rd_sharers,
    output llc_pkg::owner_t     [LLC_WAYS-1:0]   rd_owner,
    output llc_pkg::hprot_t     [LLC_WAYS-1:0]   rd_hprot,
    output logic                [LLC_WAYS-1:0]   rd_dirty
);

    for (genvar w = 0; w < LLC_WAYS; w++) begin : g_way
        llc_pkg::llc_tag_t   tag_mem     [LLC_SETS];
        llc_pkg::llc_state_t state_mem   [LLC_SETS];
        llc_pkg::sharers_t   sharers_mem [LLC_SETS];
        llc_pkg::owner_t     owner_mem   [LLC_SETS];
        llc_pkg::hprot_t     hprot_mem   [LLC_SETS];
        logic                dirty_mem   [LLC_SETS];

        llc_pkg::llc_tag_t   tag_q;
        llc_pkg::llc_state_t state_q;
        llc_pkg::sharers_t   sharers_q;
        llc_pkg::owner_t     owner_q;
        llc_pkg::hprot_t     hprot_q;
        logic                dirty_q;

        always_ff @(posedge clk) begin
            if (mem_if.wr_ways[w]) begin
                tag_mem[mem_if.set]     <= mem_if.tag;
                state_mem[mem_if.set]   <= mem_if.state;
                sharers_mem[mem_if.set] <= mem_if.sharers;
                owner_mem[mem_if.set]   <= mem_if.owner;
                hprot_mem[mem_if.set]   <= mem_if.hprot;
                dirty_mem[mem_if.set]   <= mem_if.dirty;
            end else if (mem_if.clr_ways[w]) begin
                // tag, owner and hprot survive a flush
                state_mem[mem_if.set]   <= llc_pkg::LLC_STATE_INVALID;
                sharers_mem[mem_if.set] <= '0;
                dirty_mem[mem_if.set]   <= 1'b0;
            end
        end

        // old contents on a same-cycle write, read-before-write
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                tag_q     <= '0;
                state_q   <= '0;
                sharers_q <= '0;
                owner_q   <= '0;
                hprot_q   <= '0;
                dirty_q   <= 1'b0;
            end else if (mem_if.rd_en) begin
                tag_q     <= tag_mem[mem_if.set];
                state_q   <= state_mem[mem_if.set];
                sharers_q <= sharers_mem[mem_if.set];
                owner_q   <= owner_mem[mem_if.set];
                hprot_q   <= hprot_mem[mem_if.set];
                dirty_q   <= dirty_mem[mem_if.set];
            end
        end

        assign rd_tag[w]     = tag_q;
        assign rd_state[w]   = state_q;
        assign rd_sharers[w] = sharers_q;
        assign rd_owner[w]   = owner_q;
        assign rd_hprot[w]   = hprot_q;
        assign rd_dirty[w]   = dirty_q;
    end

    // the controller decodes a single way per write
    a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(mem_if.wr_ways));

endmodule

`default_nettype wire

/* hw/llc_line_mem.sv */
// cache line data per way, untouched by a flush
`timescale 1ns/1ps
`default_nettype none

module llc_line_mem #(
    parameter int LLC_WAYS = 4,
    parameter int LLC_SETS = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    llc_mem_if.mem                         mem_if,
    output llc_pkg::line_t [LLC_WAYS-1:0]  rd_line
);

    for (genvar w = 0; w < LLC_WAYS; w++) begin : g_way
        llc_pkg::line_t line_mem [LLC_SETS];
        llc_pkg::line_t line_q;

        always_ff @(posedge clk) begin
            if (mem_if.wr_ways[w]) begin
                line_mem[mem_if.set] <= mem_if.line;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                line_q <= '0;
            end else if (mem_if.rd_en) begin
                line_q <= line_mem[mem_if.set];
            end
        end

        assign rd_line[w] = line_q;
    end

endmodule

`default_nettype wire

/* hw/llc_evict_mem.sv */
// evict-way pointer, one per set, kept across a flush
`timescale 1ns/1ps
`default_nettype none

module llc_evict_mem #(
    parameter int LLC_WAYS = 4,
    parameter int LLC_SETS = 16,
    localparam int WAY_BITS = $clog2(LLC_WAYS)
) (
    input  logic                clk,
    input  logic                rst_n,
    llc_mem_if.mem              mem_if,
    output logic [WAY_BITS-1:0] rd_evict_way
);

    logic [WAY_BITS-1:0] evict_mem [LLC_SETS];

    always_ff @(posedge clk) begin
        if (mem_if.wr_evict) begin
            evict_mem[mem_if.set] <= mem_if.evict_way;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_evict_way <= '0;
        end else if (mem_if.rd_en) begin
            rd_evict_way <= evict_mem[mem_if.set];
        end
    end

endmodule

`default_nettype wire

/* hw/llc_localmem.sv */
// LLC local memory, one-cycle read of all ways, no ready handshake
// commands are dropped while busy; a full flush runs after every reset
`timescale 1ns/1ps
`default_nettype none

module llc_localmem #(
    parameter int LLC_WAYS = 4,
    parameter int LLC_SETS = 16,
    localparam int WAY_BITS = $clog2(LLC_WAYS),
    localparam int SET_BITS = $clog2(LLC_SETS)
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush_req,
    input  logic                                rd_en,
    input  logic                                wr_en,
    input  logic                                wr_en_evict_way,
    input  logic [SET_BITS-1:0]                 set_in,
    input  logic [WAY_BITS-1:0]                 way,
    input  llc_pkg::llc_tag_t                   wr_data_tag,
    input  llc_pkg::llc_state_t                 wr_data_state,
    input  llc_pkg::sharers_t                   wr_data_sharers,
    input  llc_pkg::owner_t                     wr_data_owner,
    input  llc_pkg::hprot_t                     wr_data_hprot,
    input  logic                                wr_data_dirty_bit,
    input  llc_pkg::line_t                      wr_data_line,
    input  logic [WAY_BITS-1:0]                 wr_data_evict_way,
    output logic                                busy,
    output llc_pkg::llc_tag_t   [LLC_WAYS-1:0]  rd_data_tag,
    output llc_pkg::llc_state_t [LLC_WAYS-1:0]  rd_data_state,
    output llc_pkg::sharers_t   [LLC_WAYS-1:0]  rd_data_sharers,
    output llc_pkg::owner_t     [LLC_WAYS-1:0]  rd_data_owner,
    output llc_pkg::hprot_t     [LLC_WAYS-1:0]  rd_data_hprot,
    output logic                [LLC_WAYS-1:0]  rd_data_dirty_bit,
    output llc_pkg::line_t      [LLC_WAYS-1:0]  rd_data_line,
    output logic [WAY_BITS-1:0]                 rd_data_evict_way
);

    logic                cnt_en;
    logic [SET_BITS-1:0] cnt_set;
    logic                cnt_last;

    llc_mem_if #(.LLC_WAYS(LLC_WAYS), .LLC_SETS(LLC_SETS)) mem_if ();

    llc_flush_ctrl #(.LLC_WAYS(LLC_WAYS), .LLC_SETS(LLC_SETS)) i_flush_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush_req         (flush_req),
        .rd_en             (rd_en),
        .wr_en             (wr_en),
        .wr_en_evict_way   (wr_en_evict_way),
        .set_in            (set_in),
        .way               (way),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_sharers   (wr_data_sharers),
        .wr_data_owner     (wr_data_owner),
        .wr_data_hprot     (wr_data_hprot),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_line      (wr_data_line),
        .wr_data_evict_way (wr_data_evict_way),
        .cnt_en            (cnt_en),
        .cnt_set           (cnt_set),
        .cnt_last          (cnt_last),
        .busy              (busy),
        .mem_if            (mem_if.ctrl)
    );

    llc_set_counter #(.LLC_SETS(LLC_SETS)) i_set_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (cnt_en),
        .set   (cnt_set),
        .last  (cnt_last)
    );

    llc_meta_mem #(.LLC_WAYS(LLC_WAYS), .LLC_SETS(LLC_SETS)) i_meta_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_if     (mem_if.mem),
        .rd_tag     (rd_data_tag),
        .rd_state   (rd_data_state),
        .rd_sharers (rd_data_sharers),
        .rd_owner   (rd_data_owner),
        .rd_hprot   (rd_data_hprot),
        .rd_dirty   (rd_data_dirty_bit)
    );

    llc_line_mem #(.LLC_WAYS(LLC_WAYS), .LLC_SETS(LLC_SETS)) i_line_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_if  (mem_if.mem),
        .rd_line (rd_data_line)
    );

    llc_evict_mem #(.LLC_WAYS(LLC_WAYS), .LLC_SETS(LLC_SETS)) i_evict_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_if       (mem_if.mem),
        .rd_evict_way (rd_data_evict_way)
    );

endmodule

`default_nettype wire

/* dv/llc_localmem_tb.sv */
// self-checking testbench for the LLC local memory with default LLC_WAYS and LLC_SETS
// tag, owner, hprot and line go unchecked until a full write of that set and way
`timescale 1ns/1ps
`default_nettype none

module llc_localmem_tb;

    localparam int LLC_WAYS   = 4;
    localparam int LLC_SETS   = 16;
    localparam int WAY_BITS   = $clog2(LLC_WAYS);
    localparam int SET_BITS   = $clog2(LLC_SETS);
    localparam int ENTRY_BITS = llc_pkg::LLC_TAG_BITS + llc_pkg::LLC_STATE_BITS
        + llc_pkg::LLC_SHARERS_BITS + llc_pkg::LLC_OWNER_BITS + 2 + llc_pkg::LLC_LINE_BITS;
    // twice the cycles of reset, both flushes, three read sweeps, the fill and the random loops
    localparam int TIMEOUT_CYCLES = 2 * (16 + 5 * LLC_SETS + LLC_SETS * LLC_WAYS
        + 2 * 24 + 32 + 3 * 8 + 8 + 10);

    typedef logic [ENTRY_BITS-1:0] entry_t;

    logic clk = 1'b0;
    logic rst_n;
    logic flush_req;
    logic rd_en;
    logic wr_en;
    logic wr_en_evict_way;
    logic busy;
    logic [SET_BITS-1:0] set_in;
    logic [WAY_BITS-1:0] way;
    llc_pkg::llc_tag_t   wr_data_tag;
    llc_pkg::llc_state_t wr_data_state;
    llc_pkg::sharers_t   wr_data_sharers;
    llc_pkg::owner_t     wr_data_owner;
    llc_pkg::hprot_t     wr_data_hprot;
    logic                wr_data_dirty_bit;
    llc_pkg::line_t      wr_data_line;
    logic [WAY_BITS-1:0] wr_data_evict_way;
    llc_pkg::llc_tag_t   [LLC_WAYS-1:0] rd_data_tag;
    llc_pkg::llc_state_t [LLC_WAYS-1:0] rd_data_state;
    llc_pkg::sharers_t   [LLC_WAYS-1:0] rd_data_sharers;
    llc_pkg::owner_t     [LLC_WAYS-1:0] rd_data_owner;
    llc_pkg::hprot_t     [LLC_WAYS-1:0] rd_data_hprot;
    logic                [LLC_WAYS-1:0] rd_data_dirty_bit;
    llc_pkg::line_t      [LLC_WAYS-1:0] rd_data_line;
    logic [WAY_BITS-1:0] rd_data_evict_way;

    // shadow model of the arrays
    llc_pkg::llc_tag_t   m_tag     [LLC_SETS][LLC_WAYS];
    llc_pkg::llc_state_t m_state   [LLC_SETS][LLC_WAYS];
    llc_pkg::sharers_t   m_sharers [LLC_SETS][LLC_WAYS];
    llc_pkg::owner_t     m_owner   [LLC_SETS][LLC_WAYS];
    llc_pkg::hprot_t     m_hprot   [LLC_SETS][LLC_WAYS];
    logic                m_dirty   [LLC_SETS][LLC_WAYS];
    llc_pkg::line_t      m_line    [LLC_SETS][LLC_WAYS];
    bit                  m_known   [LLC_SETS][LLC_WAYS];
    logic [WAY_BITS-1:0] m_evict   [LLC_SETS];
    bit                  m_evict_known [LLC_SETS];

    // read expected one cycle after its accepting edge
    entry_t              exp_entry [LLC_WAYS];
    entry_t              exp_mask  [LLC_WAYS];
    logic [WAY_BITS-1:0] exp_evict;
    bit                  exp_evict_known;
    bit                  rd_pending;
    string               exp_name;
    string               test_name = "reset";
    logic [31:0]         lfsr;
    int                  rd_issued = 0;
    int                  rd_compared = 0;
    int                  cycles = 0;

    llc_localmem i_llc_localmem (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycles, test_name);
            $display("*** FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[126:0], fb};
        end
        return r;
    endfunction

    function automatic entry_t pack_entry(input llc_pkg::llc_tag_t tag,
            input llc_pkg::llc_state_t state, input llc_pkg::sharers_t sharers,
            input llc_pkg::owner_t owner, input llc_pkg::hprot_t hprot,
            input logic dirty, input llc_pkg::line_t line);
        return {tag, state, sharers, owner, hprot, dirty, line};
    endfunction

    function automatic entry_t expected_entry(input logic [SET_BITS-1:0] s,
                                              input logic [WAY_BITS-1:0] w);
        return pack_entry(m_tag[s][w], m_state[s][w], m_sharers[s][w], m_owner[s][w],
                          m_hprot[s][w], m_dirty[s][w], m_line[s][w]);
    endfunction

    // only state, sharers and dirty are defined before the first full write
    function automatic entry_t entry_mask(input logic [SET_BITS-1:0] s,
                                          input logic [WAY_BITS-1:0] w);
        return m_known[s][w] ? '1 : pack_entry('0, '1, '1, '0, '0, 1'b1, '0);
    endfunction

    task automatic check(input string name, input entry_t expected, input entry_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic model_clear();
        foreach (m_state[i, j]) begin
            m_state[i][j]   = llc_pkg::LLC_STATE_INVALID;
            m_sharers[i][j] = '0;
            m_dirty[i][j]   = 1'b0;
        end
    endtask

    // compare the previous read and record what the next edge accepts
    always @(negedge clk) begin : compare_reads
        entry_t              got;
        logic [WAY_BITS-1:0] w;
        logic [SET_BITS-1:0] s;
        if (rd_pending) begin
            for (int i = 0; i < LLC_WAYS; i++) begin
                w = WAY_BITS'(i);
                got = pack_entry(rd_data_tag[w], rd_data_state[w], rd_data_sharers[w],
                                 rd_data_owner[w], rd_data_hprot[w], rd_data_dirty_bit[w],
                                 rd_data_line[w]);
                check(exp_name, exp_entry[w] & exp_mask[w], got & exp_mask[w]);
            end
            if (exp_evict_known) begin
                check({exp_name, "/evict"}, entry_t'(exp_evict), entry_t'(rd_data_evict_way));
            end
            rd_compared++;
        end
        rd_pending = 1'b0;
        s = set_in;
        if (rst_n && !busy) begin
            if (rd_en) begin
                for (int i = 0; i < LLC_WAYS; i++) begin
                    w = WAY_BITS'(i);
                    exp_entry[w] = expected_entry(s, w);
                    exp_mask[w]  = entry_mask(s, w);
                end
                exp_evict       = m_evict[s];
                exp_evict_known = m_evict_known[s];
                exp_name        = test_name;
                rd_pending      = 1'b1;
            end
            if (wr_en) begin
                m_tag[s][way]     = wr_data_tag;
                m_state[s][way]   = wr_data_state;
                m_sharers[s][way] = wr_data_sharers;
                m_owner[s][way]   = wr_data_owner;
                m_hprot[s][way]   = wr_data_hprot;
                m_dirty[s][way]   = wr_data_dirty_bit;
                m_line[s][way]    = wr_data_line;
                m_known[s][way]   = 1'b1;
            end
            if (wr_en_evict_way) begin
                m_evict[s]       = wr_data_evict_way;
                m_evict_known[s] = 1'b1;
            end
            if (flush_req) begin
                model_clear();
            end
        end
    end

    task automatic clear_cmds();
        rd_en           = 1'b0;
        wr_en           = 1'b0;
        wr_en_evict_way = 1'b0;
        flush_req       = 1'b0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        clear_cmds();
    endtask

    task automatic drive_fields();
        wr_data_tag       = llc_pkg::llc_tag_t'(rand_bits(llc_pkg::LLC_TAG_BITS));
        wr_data_state     = llc_pkg::llc_state_t'(rand_bits(llc_pkg::LLC_STATE_BITS));
        wr_data_sharers   = llc_pkg::sharers_t'(rand_bits(llc_pkg::LLC_SHARERS_BITS));
        wr_data_owner     = llc_pkg::owner_t'(rand_bits(llc_pkg::LLC_OWNER_BITS));
        wr_data_hprot     = llc_pkg::hprot_t'(rand_bits(1));
        wr_data_dirty_bit = 1'(rand_bits(1));
        wr_data_line      = rand_bits(llc_pkg::LLC_LINE_BITS);
        wr_data_evict_way = WAY_BITS'(rand_bits(WAY_BITS));
    endtask

    task automatic issue_read(input int s);
        next_cycle();
        rd_en  = 1'b1;
        set_in = SET_BITS'(s);
        rd_issued++;
    endtask

    task automatic issue_write(input int s, input int w, input bit with_evict);
        next_cycle();
        drive_fields();
        wr_en           = 1'b1;
        wr_en_evict_way = with_evict;
        set_in          = SET_BITS'(s);
        way             = WAY_BITS'(w);
    endtask

    // counts busy cycles and can hammer the DUT with commands that must be dropped
    task automatic busy_window(input bit poke);
        int n;
        n = 0;
        while (busy === 1'b1) begin
            n++;
            if (poke) begin
                drive_fields();
                {rd_en, wr_en, wr_en_evict_way} = 3'b111;
                set_in = SET_BITS'(rand_bits(SET_BITS));
                way    = WAY_BITS'(rand_bits(WAY_BITS));
            end
            next_cycle();
        end
        check({test_name, "/busy_cycles"}, entry_t'(LLC_SETS), entry_t'(n));
    endtask

    initial begin : main_seq
        int s;
        lfsr   = 32'hd89f;
        rst_n  = 1'b0;
        set_in = '0;
        way    = '0;
        clear_cmds();
        drive_fields();
        model_clear();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_name = "reset_flush";
        busy_window(1'b0);
        test_name = "reset_read";
        for (int i = 0; i < LLC_SETS; i++) issue_read(i);
        test_name = "fill";
        for (int i = 0; i < LLC_SETS * LLC_WAYS; i++) begin
            issue_write(i / LLC_WAYS, i % LLC_WAYS, 1'b1);
        end
        for (int i = 0; i < LLC_SETS; i++) issue_read(i);
        test_name = "write_read";
        repeat (24) begin
            s = int'(rand_bits(SET_BITS));
            issue_write(s, int'(rand_bits(WAY_BITS)), 1'b0);
            issue_read(s);
        end
        test_name = "b2b_read";
        repeat (32) begin
            // each read goes to a set other than the one before it
            s = (s + 1 + int'(rand_bits(SET_BITS)) % (LLC_SETS - 1)) % LLC_SETS;
            issue_read(s);
        end
        test_name = "evict";
        repeat (8) begin
            s = int'(rand_bits(SET_BITS));
            next_cycle();
            drive_fields();
            wr_en_evict_way = 1'b1;
            set_in          = SET_BITS'(s);
            issue_read(s);
            issue_read((s + 1 + int'(rand_bits(SET_BITS)) % (LLC_SETS - 1)) % LLC_SETS);
        end
        test_name = "flush";
        repeat (8) issue_write(int'(rand_bits(SET_BITS)), int'(rand_bits(WAY_BITS)), 1'b1);
        next_cycle();
        flush_req = 1'b1;
        next_cycle();
        busy_window(1'b1);
        for (int i = 0; i < LLC_SETS; i++) issue_read(i);
        next_cycle();
        next_cycle();
        if (rd_issued > 0 && rd_compared == rd_issued) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("only %0d of %0d read results were compared", rd_compared, rd_issued);
            $display("*** FAILED ***");
            $fatal(1, "read results missing");
        end
    end

endmodule

`default_nettype wire

/* flist.f */
hw/llc_pkg.sv
hw/llc_mem_if.sv
hw/llc_flush_ctrl.sv
hw/llc_set_counter.sv
hw/llc_meta_mem.sv
hw/llc_line_mem.sv
hw/llc_evict_mem.sv
hw/llc_localmem.sv
dv/llc_localmem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the LLC local memory testbench with Verilator and runs it
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f flist.f --top-module llc_localmem_tb \
    -o llc_localmem_sim && \
./obj_dir/llc_localmem_sim || { echo "simulation failed"; exit 1; }
